// ==== Bender.yml ====
package:
  name: token_loader

sources:
  - verilog/token_pkg.sv
  - verilog/cmd_pkg.sv
  - verilog/token_fifo.sv
  - verilog/mem_controller.sv
  - verilog/token_ram.sv
  - verilog/cmd_executor.sv
  - verilog/token_loader_top.sv
  - target: test
    files:
      - dv/tb_token_loader.sv

// ==== dv/tb_token_loader.sv ====
// Self-checking testbench for the token loader; loads command and data streams and checks results
`timescale 1ns/1ps

module tb_token_loader;
	import token_pkg::*;
	import cmd_pkg::*;

	typedef word_t word_q_t[$];

	logic  clk = 1'b0;
	logic  rst = 1'b0;          // Held low from time zero
	word_t cmd_token = '0;
	logic  cmd_push = 1'b0;
	word_t data_token = '0;
	logic  data_push = 1'b0;
	logic  cmd_full;
	logic  data_full;
	word_t result;
	logic  result_valid;

	int      mismatch_errors = 0;
	int      timeout_errors = 0;
	int      other_errors = 0;
	int      n_results = 0;     // Results seen since the last reset
	word_t   exp_q[$];          // Pending expected results, oldest first
	word_q_t cmds;              // Program of the current case
	word_q_t data;              // Data words of the current case

	token_loader_top i_dut (
		.clk(clk), .rst(rst), .cmd_token(cmd_token), .cmd_push(cmd_push),
		.data_token(data_token), .data_push(data_push), .cmd_full(cmd_full),
		.data_full(data_full), .result(result), .result_valid(result_valid)
	);

	always #50 clk = ~clk; // 100 ns period

	// Command words built from the field layout
	function automatic word_t mem_cmd(opcode_e op, int addr);
		return {op, 2'b00, addr_t'(addr)};
	endfunction

	function automatic word_t imm_cmd(opcode_e op, int imm);
		return {op, 12'(imm)};
	endfunction

	// Reference model of the executor, acc starts at zero after reset
	function automatic word_q_t ref_results(input word_t c[$], input word_t d[$]);
		word_q_t res;
		word_t   acc;
		opcode_e op;
		int      a;
		acc = '0;
		foreach (c[i])
		begin
			op = opcode_e'(c[i][15:12]);
			a  = int'(c[i][9:0]); // Memory view address
			case (op)
				LDI:     acc = {{4{c[i][11]}}, c[i][11:0]};
				LOAD:    acc = d[a];
				ADD:     acc = acc + d[a];
				SUB:     acc = acc - d[a];
				OUT:     res.push_back(acc);
				default: ; // NOP and unknown codes
			endcase
		end
		return res;
	endfunction

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp)
		begin
			mismatch_errors++;
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp)
		begin
			mismatch_errors++;
			$display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// Compares every result at mid-cycle, where outputs are settled
	always @(negedge clk)
	begin
		if (rst && result_valid)
		begin
			n_results++;
			if (exp_q.size() == 0)
			begin
				other_errors++;
				$display("Result %h at %0t arrived with no result expected", result, $time);
			end
			else
				check_word("result", result, exp_q.pop_front());
		end
	end

	task automatic apply_reset();
		rst       = 1'b0;
		cmd_push  = 1'b0;
		data_push = 1'b0;
		repeat (5) @(negedge clk);
		exp_q.delete();
		n_results = 0;
		rst = 1'b1;
	endtask

	// One stimulus cycle; waits while a requested FIFO is full
	task automatic push_step(logic do_cmd, word_t cw, logic do_data, word_t dw);
		int t;
		t = 0;
		while (((do_cmd && cmd_full) || (do_data && data_full)) && t < 5000)
		begin
			@(negedge clk);
			t++;
		end
		if (t >= 5000)
		begin
			timeout_errors++;
			$display("Timeout at %0t: FIFO stayed full for %0d cycles", $time, t);
		end
		cmd_push   = do_cmd;
		cmd_token  = cw;
		data_push  = do_data;
		data_token = dw;
		@(negedge clk);
		cmd_push  = 1'b0;
		data_push = 1'b0;
	endtask

	task automatic wait_results(int n, int limit, string what);
		int t;
		t = 0;
		while (n_results < n && t < limit)
		begin
			@(negedge clk);
			t++;
		end
		if (n_results < n)
		begin
			timeout_errors++;
			$display("Timeout in %s: %0d of %0d results after %0d cycles", what, n_results, n, t);
		end
		repeat (40) @(negedge clk); // Room for stray results
		if (n_results != n)
		begin
			other_errors++;
			$display("In %s %0d results were seen but %0d were expected", what, n_results, n);
		end
	endtask

	// Loads the whole program and data in one order, then waits for all results
	task automatic play_program(logic cmds_first, string what);
		apply_reset();
		exp_q = ref_results(cmds, data);
		if (cmds_first)
		begin
			foreach (cmds[i]) push_step(1'b1, cmds[i], 1'b0, '0);
			foreach (data[i]) push_step(1'b0, '0, 1'b1, data[i]);
		end
		else
		begin
			foreach (data[i]) push_step(1'b0, '0, 1'b1, data[i]);
			foreach (cmds[i]) push_step(1'b1, cmds[i], 1'b0, '0);
		end
		wait_results(exp_q.size() + n_results, 20 * (cmds.size() + data.size()) + 2000, what);
	endtask

	task automatic idle_after_reset();
		apply_reset();
		repeat (20)
		begin
			@(negedge clk);
			check_flag("result_valid", result_valid, 1'b0);
			check_flag("cmd_full", cmd_full, 1'b0);
			check_flag("data_full", data_full, 1'b0);
			check_word("result", result, '0); // Accumulator cleared by reset
		end
	endtask

	// Interleaved pushes with idle gaps, addresses only inside the planned data set
	task automatic random_interleave();
		int ci;
		int di;
		int n_out;
		int r;
		cmds.delete();
		data.delete();
		n_out = 0;
		for (int i = 0; i < 60; i++) data.push_back(word_t'($urandom));
		for (int i = 0; i < 140; i++)
		begin
			r = $urandom_range(0, 6);
			case (r)
				0: cmds.push_back(imm_cmd(NOP, $urandom));
				1: cmds.push_back(imm_cmd(LDI, $urandom));
				2: cmds.push_back(mem_cmd(LOAD, $urandom_range(0, 59)));
				3: cmds.push_back(mem_cmd(ADD, $urandom_range(0, 59)));
				4: cmds.push_back(mem_cmd(SUB, $urandom_range(0, 59)));
				5: cmds.push_back(imm_cmd(OUT, $urandom));
				default: cmds.push_back({4'hf, 12'($urandom)}); // Unknown opcode
			endcase
			if (r == 5)
				n_out++;
		end
		apply_reset();
		exp_q = ref_results(cmds, data);
		ci = 0;
		di = 0;
		while (ci < cmds.size() || di < data.size())
		begin
			if ($urandom_range(0, 3) == 0)
				repeat ($urandom_range(1, 6)) @(negedge clk); // Idle gap
			r = $urandom_range(1, 3); // Bit 0 pushes a command, bit 1 pushes data
			push_step(r[0] && ci < cmds.size(), cmds[ci], r[1] && di < data.size(), data[di]);
			if (r[0] && ci < cmds.size())
				ci++;
			if (r[1] && di < data.size())
				di++;
		end
		wait_results(n_out, 20 * 200 + 2000, "random interleave");
	endtask

	// Data at full rate, then each word read back through LOAD and OUT
	task automatic data_back_pressure();
		cmds.delete();
		data.delete();
		for (int i = 0; i < 300; i++)
		begin
			data.push_back(word_t'($urandom));
			cmds.push_back(mem_cmd(LOAD, i));
			cmds.push_back(imm_cmd(OUT, 0));
		end
		apply_reset();
		exp_q = ref_results(cmds, data);
		foreach (data[i])
		begin
			check_flag("data_full", data_full, 1'b0); // 300 words never reach the depth
			push_step(1'b0, '0, 1'b1, data[i]);
		end
		foreach (cmds[i]) push_step(1'b1, cmds[i], 1'b0, '0);
		wait_results(300, 20 * 900 + 2000, "back-pressure");
	endtask

	initial
	begin
		void'($urandom(73392));
		idle_after_reset();

		// Fixed program with data loaded first, both union views
		cmds = '{imm_cmd(LDI, -5), imm_cmd(OUT, 0), imm_cmd(LDI, 12'h7ff), imm_cmd(OUT, 0),
			mem_cmd(LOAD, 3), mem_cmd(ADD, 5), mem_cmd(SUB, 7), imm_cmd(OUT, 0),
			imm_cmd(LDI, -2048), mem_cmd(SUB, 1), imm_cmd(OUT, 0), imm_cmd(NOP, 0),
			imm_cmd(OUT, 0)};
		data.delete();
		for (int i = 0; i < 8; i++) data.push_back(word_t'($urandom));
		play_program(1'b0, "fixed program");

		// Commands ahead of their data, executor stalls on the fill count
		cmds = '{mem_cmd(LOAD, 15), imm_cmd(OUT, 0), mem_cmd(ADD, 0), imm_cmd(OUT, 0),
			mem_cmd(SUB, 9), imm_cmd(OUT, 0), imm_cmd(LDI, -1), mem_cmd(ADD, 15), imm_cmd(OUT, 0)};
		data.delete();
		for (int i = 0; i < 16; i++) data.push_back(word_t'($urandom));
		play_program(1'b1, "commands first");

		random_interleave();
		data_back_pressure();

		$display("Errors: %0d mismatches, %0d timeouts, %0d other",
			mismatch_errors, timeout_errors, other_errors);
		if (mismatch_errors + timeout_errors + other_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/token_pkg.sv
verilog/cmd_pkg.sv
verilog/token_fifo.sv
verilog/mem_controller.sv
verilog/token_ram.sv
verilog/cmd_executor.sv
verilog/token_loader_top.sv
dv/tb_token_loader.sv

// ==== verilog/cmd_executor.sv ====
// Fetches commands from the command RAM, reads the data RAM when needed and emits results
`timescale 1ns/1ps

module cmd_executor (
	input  logic             clk,
	input  logic             rst,
	input  token_pkg::addr_t cmd_fill,     // Commands loaded so far
	input  token_pkg::addr_t data_fill,    // Data words loaded so far
	output token_pkg::addr_t cmd_rd_addr,
	input  token_pkg::word_t cmd_rd_data,
	output token_pkg::addr_t data_rd_addr,
	input  token_pkg::word_t data_rd_data,
	output token_pkg::word_t result,
	output logic             result_valid  // One-cycle pulse per OUT
);
	import token_pkg::*;
	import cmd_pkg::*;

	typedef enum logic [2:0] {
		st_idle      = 3'd0, // Wait for a loaded command
		st_fetch     = 3'd1, // Command address applied
		st_decode    = 3'd2, // Command word arrives
		st_wait_data = 3'd3, // Wait for the operand to be loaded
		st_read_data = 3'd4, // Data address applied
		st_apply     = 3'd5  // Update acc or emit
	} state_e;

	state_e    state;
	state_e    next_state;
	addr_t     cmd_ptr; // Next command to run
	cmd_word_u cmd_in;  // Word from the command RAM
	cmd_word_u cmd_q;   // Decoded command
	word_t     acc;

	assign cmd_in = cmd_rd_data;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state   <= st_idle;
			cmd_ptr <= '0;
			acc     <= '0;
		end
		else
		begin
			state <= next_state;
			if (state == st_apply)
			begin
				cmd_ptr <= cmd_ptr + 1'b1;
				case (cmd_q.mem.opcode)
					LDI:     acc <= sext_imm(cmd_q.imm.imm); // Immediate view
					LOAD:    acc <= data_rd_data;            // Memory view
					ADD:     acc <= acc + data_rd_data;      // Wraps mod 2^word_size
					SUB:     acc <= acc - data_rd_data;
					default: acc <= acc;                     // NOP, OUT, unknown
				endcase
			end
		end
	end

	// Command register, loaded on decode
	always_ff @(posedge clk)
	begin
		if (state == st_decode)
			cmd_q <= cmd_in;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
				if (cmd_ptr < cmd_fill)
					next_state = st_fetch;
			st_fetch:  next_state = st_decode;
			st_decode: next_state = is_mem_op(cmd_in.mem.opcode) ? st_wait_data : st_apply;
			st_wait_data:
				if (cmd_q.mem.addr < data_fill)
					next_state = st_read_data;
			st_read_data: next_state = st_apply;
			st_apply:     next_state = st_idle;
			default:      next_state = st_idle;
		endcase
	end

	assign cmd_rd_addr  = cmd_ptr;
	assign data_rd_addr = cmd_q.mem.addr; // Held through apply so rd_data stays valid
	assign result       = acc;            // OUT leaves acc unchanged
	assign result_valid = (state == st_apply) && (cmd_q.mem.opcode == OUT);

	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst)
		result_valid |=> !result_valid)
		else $error("cmd_executor: result_valid longer than one cycle");

endmodule

// ==== verilog/cmd_pkg.sv ====
// Command word encoding for the executor: opcodes, the two field views and decode helpers
package cmd_pkg;

	localparam int opcode_size = 4;
	localparam int imm_size    = 12;                  // Signed immediate of LDI
	localparam int rsvd_size   = token_pkg::word_size - opcode_size - token_pkg::addr_size;

	// Codes not listed here execute as NOP
	typedef enum logic [opcode_size-1:0] {
		NOP  = 4'h0,
		LDI  = 4'h1, // acc = sext(imm)
		LOAD = 4'h2, // acc = data[addr]
		ADD  = 4'h3, // acc += data[addr]
		SUB  = 4'h4, // acc -= data[addr]
		OUT  = 4'h5  // Emit acc
	} opcode_e;

	// Memory view: opcode, reserved bits, data address
	typedef struct packed {
		opcode_e                     opcode;
		logic [rsvd_size-1:0]        rsvd;
		logic [token_pkg::addr_size-1:0] addr;
	} cmd_mem_t;

	// Immediate view: opcode and signed immediate
	typedef struct packed {
		opcode_e                     opcode;
		logic signed [imm_size-1:0]  imm;
	} cmd_imm_t;

	// Same 16 bits, read through either view
	typedef union packed {
		cmd_mem_t mem;
		cmd_imm_t imm;
	} cmd_word_u;

	// Opcodes that need a data RAM read
	function automatic logic is_mem_op(opcode_e op);
		return (op == LOAD) || (op == ADD) || (op == SUB);
	endfunction

	// Sign extension of the immediate to a full token
	function automatic token_pkg::word_t sext_imm(logic signed [imm_size-1:0] imm);
		return {{(token_pkg::word_size - imm_size){imm[imm_size-1]}}, imm};
	endfunction

endpackage

// ==== verilog/mem_controller.sv ====
// Moves tokens one at a time from an input FIFO into its RAM and keeps the RAM write address
`timescale 1ns/1ps

module mem_controller (
	input  logic              clk,
	input  logic              rst,
	input  token_pkg::count_t population,  // FIFO fill level
	input  token_pkg::word_t  in_token,    // FIFO rd_data
	output logic              rd_en,       // One-cycle pop pulse
	output logic              ram_wr_en,
	output token_pkg::addr_t  ram_wr_addr, // Also the fill count seen by the executor
	output token_pkg::word_t  ram_wr_data
);
	import token_pkg::*;

	// Five-state Moore sequence, one token per pass
	typedef enum logic [2:0] {
		st_start  = 3'd0, // Wait for a token
		st_rd_en  = 3'd1, // Pop the FIFO
		st_read   = 3'd2, // FIFO word valid, capture it
		st_wr_ram = 3'd3, // Write RAM, bump address
		st_end    = 3'd4
	} state_e;

	state_e state;
	state_e next_state;
	addr_t  wr_addr; // Tokens written so far
	word_t  token_q; // Captured token

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state   <= st_start;
			wr_addr <= '0; // Only rst brings the address back to zero
		end
		else
		begin
			state <= next_state;
			if (state == st_wr_ram)
				wr_addr <= wr_addr + 1'b1; // Advance after the write
		end
	end

	// Token holding register
	always_ff @(posedge clk)
	begin
		if (state == st_read)
			token_q <= in_token;
	end

	// Next-state logic
	always_comb
	begin
		next_state = state;
		case (state)
			st_start:
			begin
				if (population >= count_t'(1))
					next_state = st_rd_en;
			end
			st_rd_en:  next_state = st_read;
			st_read:   next_state = st_wr_ram;
			st_wr_ram: next_state = st_end;
			st_end:    next_state = st_start;
			default:   next_state = st_start;
		endcase
	end

	// Moore outputs
	always_comb
	begin
		rd_en     = (state == st_rd_en);
		ram_wr_en = (state == st_wr_ram);
	end

	assign ram_wr_addr = wr_addr;
	assign ram_wr_data = token_q;

	// Writes are spaced by the full sequence
	a_wr_spaced: assert property (@(posedge clk) disable iff (!rst) ram_wr_en |=> !ram_wr_en)
		else $error("mem_controller: back-to-back RAM writes");

endmodule

// ==== verilog/token_fifo.sv ====
// Input FIFO for one token stream; popped word shows on rd_data one cycle after rd_en
`timescale 1ns/1ps

module token_fifo (
	input  logic              clk,
	input  logic              rst,
	input  logic              push,       // Write strobe from the source
	input  token_pkg::word_t  wr_data,
	input  logic              rd_en,      // Pop strobe from the controller
	output token_pkg::word_t  rd_data,
	output token_pkg::count_t population, // Words currently held
	output logic              full
);
	import token_pkg::*;

	word_t  mem [buffer_size]; // Circular storage
	addr_t  wr_ptr;
	addr_t  rd_ptr;
	count_t count;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at buffer_size
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Push and pop together cancel
			endcase
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_ptr];
	end

	assign population = count;
	assign full       = (count == count_t'(buffer_size));

	// Source must honor full
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst) push |-> !full)
		else $error("token_fifo: push while full");
	// Controller pops only what is there
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst) rd_en |-> (count != '0))
		else $error("token_fifo: rd_en while empty");

endmodule

// ==== verilog/token_loader_top.sv ====
// Top of the loader; two FIFO/controller/RAM paths for commands and data feeding the executor
`timescale 1ns/1ps

module token_loader_top (
	input  logic             clk,
	input  logic             rst,
	input  token_pkg::word_t cmd_token,
	input  logic             cmd_push,
	input  token_pkg::word_t data_token,
	input  logic             data_push,
	output logic             cmd_full,   // Source must not push while high
	output logic             data_full,
	output token_pkg::word_t result,
	output logic             result_valid
);
	import token_pkg::*;

	// Command path
	count_t cmd_population;
	word_t  cmd_fifo_data;
	logic   cmd_fifo_rd_en;
	logic   cmd_wr_en;
	addr_t  cmd_wr_addr;   // Also command fill count
	word_t  cmd_wr_data;
	addr_t  cmd_rd_addr;
	word_t  cmd_rd_data;

	// Data path
	count_t data_population;
	word_t  data_fifo_data;
	logic   data_fifo_rd_en;
	logic   data_wr_en;
	addr_t  data_wr_addr;  // Also data fill count
	word_t  data_wr_data;
	addr_t  data_rd_addr;
	word_t  data_rd_data;

	token_fifo i_cmd_fifo (
		.clk(clk), .rst(rst), .push(cmd_push), .wr_data(cmd_token), .rd_en(cmd_fifo_rd_en),
		.rd_data(cmd_fifo_data), .population(cmd_population), .full(cmd_full)
	);

	mem_controller i_cmd_ctrl (
		.clk(clk), .rst(rst), .population(cmd_population), .in_token(cmd_fifo_data),
		.rd_en(cmd_fifo_rd_en), .ram_wr_en(cmd_wr_en), .ram_wr_addr(cmd_wr_addr),
		.ram_wr_data(cmd_wr_data)
	);

	token_ram i_cmd_ram (
		.clk(clk), .wr_en(cmd_wr_en), .wr_addr(cmd_wr_addr), .wr_data(cmd_wr_data),
		.rd_addr(cmd_rd_addr), .rd_data(cmd_rd_data)
	);

	token_fifo i_data_fifo (
		.clk(clk), .rst(rst), .push(data_push), .wr_data(data_token), .rd_en(data_fifo_rd_en),
		.rd_data(data_fifo_data), .population(data_population), .full(data_full)
	);

	mem_controller i_data_ctrl (
		.clk(clk), .rst(rst), .population(data_population), .in_token(data_fifo_data),
		.rd_en(data_fifo_rd_en), .ram_wr_en(data_wr_en), .ram_wr_addr(data_wr_addr),
		.ram_wr_data(data_wr_data)
	);

	token_ram i_data_ram (
		.clk(clk), .wr_en(data_wr_en), .wr_addr(data_wr_addr), .wr_data(data_wr_data),
		.rd_addr(data_rd_addr), .rd_data(data_rd_data)
	);

	// Executor sees each write address as the fill count of its RAM
	cmd_executor i_exec (
		.clk(clk), .rst(rst), .cmd_fill(cmd_wr_addr), .data_fill(data_wr_addr),
		.cmd_rd_addr(cmd_rd_addr), .cmd_rd_data(cmd_rd_data),
		.data_rd_addr(data_rd_addr), .data_rd_data(data_rd_data),
		.result(result), .result_valid(result_valid)
	);

endmodule

// ==== verilog/token_pkg.sv ====
// Token width, buffer depth and address types; imported by every block of the loader
package token_pkg;

	// Token and storage geometry
	localparam int word_size   = 16;                  // Bits per token
	localparam int buffer_size = 1024;                // Depth of each FIFO and RAM
	localparam int addr_size   = $clog2(buffer_size); // 10 address bits

	// One token, RAM word or result
	typedef logic [word_size-1:0] word_t;

	// RAM address, FIFO pointer and fill count
	typedef logic [addr_size-1:0] addr_t;

	// FIFO population, one bit wider so a full buffer fits
	typedef logic [addr_size:0] count_t;

	// Addresses wrap at buffer_size, nothing larger is tracked

endpackage

// ==== verilog/token_ram.sv ====
// Local token RAM; one write port, one read port with a registered read of one cycle latency
`timescale 1ns/1ps

module token_ram (
	input  logic             clk,
	input  logic             wr_en,
	input  token_pkg::addr_t wr_addr,
	input  token_pkg::word_t wr_data,
	input  token_pkg::addr_t rd_addr,
	output token_pkg::word_t rd_data // Valid the cycle after rd_addr
);
	import token_pkg::*;

	word_t mem [buffer_size];

	// Write side, driven by the controller
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Read side, driven by the executor
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr]; // Old data on a same-address write
	end

endmodule
